//--- all.f
+incdir+common
common/commit_pkg.sv
rob/reorder_buffer.sv
verilog/retire_stage.sv
verilog/arch_regfile.sv
verilog/map_table.sv
verilog/commit_top.sv
verification/commit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the commit testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module commit_tb -f all.f -o commit_sim
./obj_dir/commit_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- verification/commit_tb.sv
// directed testbench for commit_top, drives dispatch and completion strobes
// a model queue of dispatched entries predicts retire order, regfile and rename map
// every wait is bounded, a timeout counts as an error and the run carries on
`timescale 1ns/1ps
`include "commit_settings.svh"

module commit_tb;

    typedef struct packed {
        logic [`TAG_W-1:0]         tag;
        commit_pkg::dispatch_pkt_t op;
        logic [`XLEN-1:0]          value;  // filled in at completion
    } model_entry_t;

    logic                      clock;
    logic                      reset;
    logic                      dispatch_valid;
    commit_pkg::dispatch_pkt_t dispatch;
    logic                      complete_valid;
    commit_pkg::complete_pkt_t complete;
    logic [`REG_W-1:0]         read_reg;
    logic [`REG_W-1:0]         lookup_reg;
    logic [`TAG_W-1:0]         alloc_tag;
    logic                      full;
    commit_pkg::retire_pkt_t   retire;
    logic                      retire_valid;
    commit_pkg::redirect_t     redirect;
    logic                      flush_backend;
    logic [`XLEN-1:0]          read_value;
    logic                      lookup_busy;
    logic [`TAG_W-1:0]         lookup_tag;

    model_entry_t            model_q[$];     // in flight, oldest first
    commit_pkg::retire_pkt_t got_q[$];       // retires seen on the outputs
    commit_pkg::redirect_t   redirect_q[$];
    logic [`XLEN-1:0]        model_regs [`NUM_REGS];
    logic                    model_busy [`NUM_REGS];
    logic [`TAG_W-1:0]       model_tag  [`NUM_REGS];
    logic [`TAG_W-1:0]       next_tag;       // expected rob tail
    int flush_cycles;                        // flush_backend cycles not yet claimed
    int errors;
    int tests;
    int failed_tests;
    int test_start_errors;

    commit_top DUT (.*);

    always #4 clock = ~clock;  // 8 ns

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_retire(input commit_pkg::retire_pkt_t got,
                                input commit_pkg::retire_pkt_t exp);
        if (got !== exp) begin
            $display("mismatch retire: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_redirect(input commit_pkg::redirect_t got,
                                  input commit_pkg::redirect_t exp);
        if (got !== exp) begin
            $display("mismatch redirect: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // tag only counts while the entry is busy
    task automatic check_map(input string name, input logic busy, input logic [`TAG_W-1:0] tag,
                             input logic exp_busy, input logic [`TAG_W-1:0] exp_tag);
        if (busy !== exp_busy || (exp_busy && tag !== exp_tag)) begin
            $display("mismatch %s busy/tag: got %h/%h expected %h/%h",
                     name, busy, tag, exp_busy, exp_tag);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input logic [`TAG_W-1:0] got,
                             input logic [`TAG_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // outputs are registered, stable at the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            if (retire_valid) got_q.push_back(retire);
            if (redirect.take_branch) redirect_q.push_back(redirect);
            if (flush_backend) flush_cycles++;
            if (retire_valid && redirect.take_branch) begin
                $display("retire and redirect came in the same cycle");
                errors++;
            end
        end
    end

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////
    task automatic dispatch_op(input logic [`REG_W-1:0] dest, input logic writes,
                               input logic branch, input logic store);
        model_entry_t e;
        @(posedge clock);
        #1;
        check_bit("full", full, 1'b0);  // source holds off while full
        check_tag("alloc_tag", alloc_tag, next_tag);
        dispatch_valid      = 1'b1;
        dispatch.dest_reg   = dest;
        dispatch.writes_reg = writes;
        dispatch.is_branch  = branch;
        dispatch.is_store   = store;
        e.tag   = next_tag;
        e.op    = dispatch;
        e.value = '0;
        model_q.push_back(e);
        if (writes && dest != '0) begin  // x0 never renamed
            model_busy[dest] = 1'b1;
            model_tag[dest]  = next_tag;
        end
        next_tag = next_tag + 1'b1;  // wraps with the rob
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_op(input logic [`TAG_W-1:0] tag, input logic [`XLEN-1:0] value);
        @(posedge clock);
        #1;
        complete_valid     = 1'b1;
        complete.tag       = tag;
        complete.value.data = value;
        foreach (model_q[i]) begin
            if (model_q[i].tag == tag) model_q[i].value = value;
        end
        @(posedge clock);
        #1;
        complete_valid = 1'b0;
    endtask

    task automatic wait_retire(output commit_pkg::retire_pkt_t pkt, output logic ok);
        int cycles;
        cycles = 0;
        pkt    = '0;
        while (got_q.size() == 0 && cycles < 100) begin
            @(posedge clock);
            cycles++;
        end
        ok = (got_q.size() != 0);
        if (ok) pkt = got_q.pop_front();
    endtask

    task automatic wait_redirect(output commit_pkg::redirect_t rd, output logic ok);
        int cycles;
        cycles = 0;
        rd     = '0;
        while (redirect_q.size() == 0 && cycles < 100) begin
            @(posedge clock);
            cycles++;
        end
        ok = (redirect_q.size() != 0);
        if (ok) rd = redirect_q.pop_front();
    endtask

    // scoreboard, retires must follow dispatch order
    task automatic expect_retires(input int n);
        commit_pkg::retire_pkt_t got;
        commit_pkg::retire_pkt_t exp;
        model_entry_t            e;
        logic                    ok;
        for (int i = 0; i < n; i++) begin
            while (model_q.size() != 0 && model_q[0].op.is_branch) begin
                e = model_q.pop_front();  // not-taken, leaves silently
            end
            wait_retire(got, ok);
            if (!ok || model_q.size() == 0) begin
                $display("retire %0d of %0d did not come as expected", i + 1, n);
                errors++;
                return;
            end
            e = model_q.pop_front();
            exp.value        = e.value;
            exp.dest         = e.op.writes_reg ? e.op.dest_reg : '0;
            exp.tag          = e.tag;
            exp.store_commit = e.op.is_store;
            check_retire(got, exp);
            if (exp.dest != '0) begin
                model_regs[exp.dest] = exp.value;
                if (model_busy[exp.dest] && model_tag[exp.dest] == exp.tag) begin
                    model_busy[exp.dest] = 1'b0;  // still latest producer
                end
            end
        end
    endtask

    // sweep regfile and map against the model
    task automatic check_state();
        for (int r = 0; r < `NUM_REGS; r++) begin
            @(posedge clock);
            #1;
            read_reg   = (`REG_W)'(r);
            lookup_reg = (`REG_W)'(r);
            @(negedge clock);
            check_word($sformatf("x%0d", r), read_value, model_regs[r]);
            check_map($sformatf("map x%0d", r), lookup_busy, lookup_tag, model_busy[r],
                      model_tag[r]);
        end
    endtask

    task automatic finish_test(input string name);
        if (got_q.size() != 0 || redirect_q.size() != 0) begin
            $display("%0d retires and %0d redirects left unclaimed", got_q.size(),
                     redirect_q.size());
            errors++;
            got_q.delete();
            redirect_q.delete();
        end
        if (flush_cycles != 0) begin
            $display("flush_backend was high for %0d cycles with no mispredict",
                     flush_cycles);
            errors++;
            flush_cycles = 0;
        end
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_reset();
        @(negedge clock);
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("take_branch", redirect.take_branch, 1'b0);
        check_bit("flush_backend", flush_backend, 1'b0);
        check_bit("full", full, 1'b0);
        check_state();
    endtask

    task automatic test_in_order();
        logic [`TAG_W-1:0] tags [8];
        for (int i = 0; i < 8; i++) begin
            tags[i] = next_tag;
            dispatch_op((`REG_W)'(i + 3), 1'b1, 1'b0, 1'b0);
        end
        for (int i = 7; i >= 0; i--) complete_op(tags[i], $urandom);  // head done last
        expect_retires(8);
        check_state();
    endtask

    task automatic test_same_dest();
        logic [`TAG_W-1:0] first;
        logic [`TAG_W-1:0] second;
        logic [`TAG_W-1:0] zero_tag;
        first = next_tag;
        dispatch_op(5'd9, 1'b1, 1'b0, 1'b0);
        second = next_tag;
        dispatch_op(5'd9, 1'b1, 1'b0, 1'b0);
        complete_op(first, $urandom);
        expect_retires(1);
        @(posedge clock);
        #1;
        lookup_reg = 5'd9;
        @(negedge clock);
        check_map("map x9", lookup_busy, lookup_tag, 1'b1, second);  // older retire ignored
        complete_op(second, $urandom);
        expect_retires(1);
        zero_tag = next_tag;
        dispatch_op(5'd0, 1'b1, 1'b0, 1'b0);
        complete_op(zero_tag, 32'hdead_beef);
        expect_retires(1);
        check_state();
    endtask

    task automatic test_store_branch();
        logic [`TAG_W-1:0] t_store;
        logic [`TAG_W-1:0] t_branch;
        logic [`TAG_W-1:0] t_op;
        t_store = next_tag;
        dispatch_op(5'd7, 1'b0, 1'b0, 1'b1);
        t_branch = next_tag;
        dispatch_op(5'd0, 1'b0, 1'b1, 1'b0);
        t_op = next_tag;
        dispatch_op(5'd11, 1'b1, 1'b0, 1'b0);
        complete_op(t_op, $urandom);
        complete_op(t_branch, '0);  // zero word, not taken
        complete_op(t_store, $urandom);
        expect_retires(2);
        if (redirect_q.size() != 0) begin
            $display("not-taken branch raised a redirect");
            errors++;
        end
        check_state();
    endtask

    task automatic test_mispredict();
        logic [`TAG_W-1:0]        tags [5];
        logic [`XLEN-3:0]         target;
        commit_pkg::retire_word_u word;
        commit_pkg::redirect_t    got;
        commit_pkg::redirect_t    exp;
        logic                     ok;
        target = 30'($urandom) | 30'h1;
        word.branch.target = target;
        word.branch.align  = 2'b00;
        for (int i = 0; i < 5; i++) begin
            tags[i] = next_tag;
            dispatch_op((`REG_W)'(i + 12), i != 1, i == 1, 1'b0);  // slot 1 is the branch
        end
        for (int i = 4; i >= 0; i--) begin
            complete_op(tags[i], (i == 1) ? word.data : $urandom);
        end
        expect_retires(1);
        wait_redirect(got, ok);
        if (!ok) begin
            $display("timeout waiting for the redirect");
            errors++;
        end else begin
            exp.take_branch = 1'b1;
            exp.new_addr    = {target, 2'b00};
            check_redirect(got, exp);
        end
        model_q.delete();  // younger ops squashed
        for (int r = 0; r < `NUM_REGS; r++) model_busy[r] = 1'b0;
        next_tag = '0;
        repeat (20) @(posedge clock);
        if (got_q.size() != 0) begin
            $display("an op behind the taken branch retired");
            errors++;
        end
        if (flush_cycles != 1) begin
            $display("flush_backend was high for %0d cycles instead of one", flush_cycles);
            errors++;
        end
        flush_cycles = 0;
        check_state();
    endtask

    task automatic test_full_wrap();
        logic [`TAG_W-1:0] t;
        logic [`TAG_W-1:0] first;
        for (int i = 0; i < 3; i++) begin  // head off zero so the fill wraps
            t = next_tag;
            dispatch_op((`REG_W)'(i + 20), 1'b1, 1'b0, 1'b0);
            complete_op(t, $urandom);
        end
        expect_retires(3);
        first = next_tag;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            dispatch_op((`REG_W)'(i % 31 + 1), 1'b1, 1'b0, 1'b0);
        end
        @(negedge clock);
        check_bit("full", full, 1'b1);
        for (int i = 0; i < `ROB_DEPTH; i++) complete_op(first + (`TAG_W)'(i), $urandom);
        expect_retires(`ROB_DEPTH);
        @(negedge clock);
        check_bit("full", full, 1'b0);
        for (int i = 0; i < 4; i++) begin
            t = next_tag;
            dispatch_op((`REG_W)'(i + 26), 1'b1, 1'b0, 1'b0);
            complete_op(t, $urandom);
        end
        expect_retires(4);
        check_state();
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        complete_valid = 1'b0;
        complete       = '0;
        read_reg       = '0;
        lookup_reg     = '0;
        next_tag       = '0;
        flush_cycles      = 0;
        errors            = 0;
        tests             = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
            model_busy[r] = 1'b0;
            model_tag[r]  = '0;
        end
        void'($urandom(32'h9eb0));
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset();
        finish_test("reset state");
        test_in_order();
        finish_test("in-order retire");
        test_same_dest();
        finish_test("same dest and x0");
        test_store_branch();
        finish_test("store and not-taken branch");
        test_mispredict();
        finish_test("mispredict flush");
        test_full_wrap();
        finish_test("full and tag wrap");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/commit_top.sv
// commit end of the core, rob, retire stage, regfile and rename map
// ports stand in for fetch, issue and the functional units
// dispatch must be held off while full is high
// flush_backend is the single strobe for lsq, rs, fu, issue and complete clears
`timescale 1ns/1ps
`include "commit_settings.svh"

module commit_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  commit_pkg::dispatch_pkt_t dispatch,
    input  logic                      complete_valid,
    input  commit_pkg::complete_pkt_t complete,
    input  logic [`REG_W-1:0]         read_reg,
    input  logic [`REG_W-1:0]         lookup_reg,
    output logic [`TAG_W-1:0]         alloc_tag,
    output logic                      full,
    output commit_pkg::retire_pkt_t   retire,
    output logic                      retire_valid,
    output commit_pkg::redirect_t     redirect,
    output logic                      flush_backend,
    output logic [`XLEN-1:0]          read_value,
    output logic                      lookup_busy,
    output logic [`TAG_W-1:0]         lookup_tag
);

    commit_pkg::rob_retire_pkt_t head_pkt;  // rob head to retire
    logic                        rob_valid;
    logic                        rob_ready;
    logic                        clear_rob;
    logic                        clear_map_table;

    ////////////////////////////////////////
    // block instances
    ////////////////////////////////////////
    reorder_buffer rob (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .complete_valid(complete_valid), .complete(complete),
        .clear_rob(clear_rob),
        .alloc_tag(alloc_tag), .full(full),
        .head_pkt(head_pkt), .rob_valid(rob_valid), .rob_ready(rob_ready)
    );

    retire_stage rt (
        .clock(clock), .reset(reset),
        .head_pkt(head_pkt), .rob_valid(rob_valid), .rob_ready(rob_ready),
        .retire(retire), .retire_valid(retire_valid), .redirect(redirect),
        .clear_rob(clear_rob), .clear_map_table(clear_map_table),
        .flush_backend(flush_backend)
    );

    arch_regfile rf (
        .clock(clock), .reset(reset),
        .retire(retire), .retire_valid(retire_valid),
        .read_reg(read_reg), .read_value(read_value)
    );

    map_table mt (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch), .alloc_tag(alloc_tag),
        .retire(retire), .retire_valid(retire_valid),
        .clear_map_table(clear_map_table),
        .lookup_reg(lookup_reg), .lookup_busy(lookup_busy), .lookup_tag(lookup_tag)
    );

endmodule

//--- verilog/map_table.sv
// rename map, one busy bit and producer tag per architectural register
// a retire only frees the entry if it is still the latest producer
// same-cycle dispatch to the register wins over retire, a clear wins over both
// x0 is never renamed
`timescale 1ns/1ps
`include "commit_settings.svh"

module map_table (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  commit_pkg::dispatch_pkt_t dispatch,
    input  logic [`TAG_W-1:0]         alloc_tag,
    input  commit_pkg::retire_pkt_t   retire,
    input  logic                      retire_valid,
    input  logic                      clear_map_table,
    input  logic [`REG_W-1:0]         lookup_reg,
    output logic                      lookup_busy,
    output logic [`TAG_W-1:0]         lookup_tag
);

    logic [`NUM_REGS-1:0] busy_q;
    logic [`TAG_W-1:0]    tag_mem [`NUM_REGS];  // latest producer per reg

    logic rename;   // dispatch claims a register
    logic release_; // retire frees its register

    assign rename   = dispatch_valid && dispatch.writes_reg && (dispatch.dest_reg != '0);
    assign release_ = retire_valid && busy_q[retire.dest] &&
                      (tag_mem[retire.dest] == retire.tag);  // older producer leaves it

    ////////////////////////////////////////
    // busy bits
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || clear_map_table) begin
            busy_q <= '0;  // everything reads from the regfile again
        end else begin
            if (release_) begin
                busy_q[retire.dest] <= 1'b0;
            end
            if (rename) begin
                busy_q[dispatch.dest_reg] <= 1'b1;  // last write wins
            end
        end
    end

    // tags are only meaningful under busy
    always_ff @(posedge clock) begin
        if (rename) begin
            tag_mem[dispatch.dest_reg] <= alloc_tag;
        end
    end

    assign lookup_busy = busy_q[lookup_reg];
    assign lookup_tag  = tag_mem[lookup_reg];

endmodule

//--- verilog/arch_regfile.sv
// committed register file, one write from retire and one combinational read
// no bypass, a read in the cycle of the write sees the old value
// x0 always reads zero and is never written
`timescale 1ns/1ps
`include "commit_settings.svh"

module arch_regfile (
    input  logic                    clock,
    input  logic                    reset,
    input  commit_pkg::retire_pkt_t retire,
    input  logic                    retire_valid,
    input  logic [`REG_W-1:0]       read_reg,
    output logic [`XLEN-1:0]        read_value
);

    logic [`XLEN-1:0] regs [`NUM_REGS];  // architectural state
    logic             write_en;

    // stores and other non-writers arrive with dest zero
    assign write_en = retire_valid && (retire.dest != '0);

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;  // machine starts from a clean state
            end
        end else if (write_en) begin
            regs[retire.dest] <= retire.value;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////
    assign read_value = (read_reg == '0) ? '0 : regs[read_reg];

endmodule

//--- verilog/retire_stage.sv
// registered retire decision for the rob head, accepts every pop, no stall
// a branch with a non-zero word is a mispredict since fetch predicts not-taken
// all clears come out of one register and are high for exactly one cycle
// entries popped during that cycle are dropped
`timescale 1ns/1ps
`include "commit_settings.svh"

module retire_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  commit_pkg::rob_retire_pkt_t head_pkt,
    input  logic                        rob_valid,
    input  logic                        rob_ready,
    output commit_pkg::retire_pkt_t     retire,
    output logic                        retire_valid,
    output commit_pkg::redirect_t       redirect,
    output logic                        clear_rob,
    output logic                        clear_map_table,
    output logic                        flush_backend
);

    logic popped;   // head leaves the rob this cycle and counts
    logic taken;    // popped branch that mispredicted
    logic flush_q;  // one-cycle mispredict strobe
    logic valid_q;
    logic store_q;

    logic [`XLEN-1:0]  value_q;
    logic [`REG_W-1:0] dest_q;
    logic [`TAG_W-1:0] tag_q;
    logic [`XLEN-1:0]  target_q;

    assign popped = rob_valid && rob_ready && !flush_q;  // squash behind a flush
    assign taken  = popped && head_pkt.is_branch && (head_pkt.value.data != '0);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            store_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            valid_q <= popped && !head_pkt.is_branch;  // branches never retire visibly
            store_q <= popped && !head_pkt.is_branch && head_pkt.is_store;
            flush_q <= taken;  // cannot repeat, popped is masked next cycle
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (popped) begin
            value_q <= head_pkt.value.data;
            dest_q  <= head_pkt.writes_reg ? head_pkt.dest_reg : '0;  // x0 means no write
            tag_q   <= head_pkt.tag;
        end
        if (taken) begin
            target_q <= {head_pkt.value.branch.target, 2'b00};  // word to byte address
        end
    end

    assign retire.value        = value_q;
    assign retire.dest         = dest_q;
    assign retire.tag          = tag_q;
    assign retire.store_commit = store_q;
    assign retire_valid        = valid_q;

    // every clear line is the same strobe
    assign redirect.take_branch = flush_q;
    assign redirect.new_addr    = target_q;
    assign clear_rob            = flush_q;
    assign clear_map_table      = flush_q;
    assign flush_backend        = flush_q;

    a_redirect_excludes_retire: assert property (
        @(posedge clock) disable iff (reset)
        redirect.take_branch |-> !retire_valid
    ) else $error("retire: redirect and retire in the same cycle");

endmodule

//--- rob/reorder_buffer.sv
// circular reorder buffer, allocates at the tail and pops the head when it is ready
// the source must not dispatch while full is high, there is no back-pressure otherwise
// a completion only sets ready, it is seen at the head one cycle later at the earliest
// clear_rob empties the buffer and wins over a dispatch in the same cycle
`timescale 1ns/1ps
`include "commit_settings.svh"

module reorder_buffer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dispatch_valid,
    input  commit_pkg::dispatch_pkt_t   dispatch,
    input  logic                        complete_valid,
    input  commit_pkg::complete_pkt_t   complete,
    input  logic                        clear_rob,
    output logic [`TAG_W-1:0]           alloc_tag,
    output logic                        full,
    output commit_pkg::rob_retire_pkt_t head_pkt,
    output logic                        rob_valid,
    output logic                        rob_ready
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    commit_pkg::dispatch_pkt_t info_mem  [`ROB_DEPTH];  // decode bits per entry
    commit_pkg::retire_word_u  value_mem [`ROB_DEPTH];  // result words

    logic [`ROB_DEPTH-1:0] valid_q;  // entry allocated
    logic [`ROB_DEPTH-1:0] ready_q;  // entry completed
    logic [`TAG_W-1:0]     head_q;   // oldest entry
    logic [`TAG_W-1:0]     tail_q;   // next free slot
    logic [`TAG_W:0]       count_q;  // one extra bit so full is visible

    logic push;
    logic pop;

    assign full      = (count_q == (`TAG_W+1)'(`ROB_DEPTH));
    assign alloc_tag = tail_q;  // good whenever full is low

    // a flush drops the dispatch, the pop is moot since everything empties
    assign push = dispatch_valid && !full && !clear_rob;
    assign pop  = rob_valid && rob_ready;

    ////////////////////////////////////////
    // payload writes
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (push) begin
            info_mem[tail_q] <= dispatch;
        end
        if (complete_valid) begin
            value_mem[complete.tag] <= complete.value;  // result lands with ready
        end
    end

    ////////////////////////////////////////
    // pointers and status bits
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || clear_rob) begin
            valid_q <= '0;
            ready_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (complete_valid) begin
                ready_q[complete.tag] <= 1'b1;
            end
            // head and tail never alias here, pop needs a valid head
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                ready_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;  // wraps at depth
            end
            if (push) begin
                valid_q[tail_q] <= 1'b1;
                ready_q[tail_q] <= 1'b0;  // waits for its completion
                tail_q          <= tail_q + 1'b1;
            end
            count_q <= count_q + (`TAG_W+1)'(push) - (`TAG_W+1)'(pop);
        end
    end

    ////////////////////////////////////////
    // head presentation
    ////////////////////////////////////////
    assign rob_valid = valid_q[head_q];
    assign rob_ready = ready_q[head_q];

    always_comb begin
        head_pkt.tag        = head_q;
        head_pkt.dest_reg   = info_mem[head_q].dest_reg;
        head_pkt.writes_reg = info_mem[head_q].writes_reg;
        head_pkt.is_branch  = info_mem[head_q].is_branch;
        head_pkt.is_store   = info_mem[head_q].is_store;
        head_pkt.value      = value_mem[head_q];
    end

    // dispatch source has to honour full, nothing stalls it here
    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_valid |-> !full
    ) else $error("rob: dispatch while full");

    // functional units may only complete tags handed out and not yet retired
    a_complete_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        complete_valid |-> valid_q[complete.tag]
    ) else $error("rob: completion to invalid entry %0d", complete.tag);

endmodule

//--- common/commit_pkg.sv
// shared types for the commit end
// a retire word is either register data or a branch target, is_branch picks the view
// a non-zero word on a branch means taken, the core predicts not-taken
`include "commit_settings.svh"

package commit_pkg;

    ////////////////////////////////////////
    // result word
    ////////////////////////////////////////
    typedef struct packed {
        logic [`XLEN-3:0] target;  // word address of the branch target
        logic [1:0]       align;   // always zero
    } branch_word_t;

    typedef union packed {
        logic [`XLEN-1:0] data;    // value for dest reg
        branch_word_t     branch;  // target view for branches
    } retire_word_u;

    ////////////////////////////////////////
    // pipeline packets
    ////////////////////////////////////////
    typedef struct packed {
        logic [`REG_W-1:0] dest_reg;
        logic              writes_reg;
        logic              is_branch;
        logic              is_store;
    } dispatch_pkt_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;    // rob entry being completed
        retire_word_u      value;
    } complete_pkt_t;

    // head entry as the rob presents it
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`REG_W-1:0] dest_reg;
        logic              writes_reg;
        logic              is_branch;
        logic              is_store;
        retire_word_u      value;
    } rob_retire_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0]  value;
        logic [`REG_W-1:0] dest;          // zero when nothing is written
        logic [`TAG_W-1:0] tag;
        logic              store_commit;  // store may go to memory
    } retire_pkt_t;

    typedef struct packed {
        logic             take_branch;
        logic [`XLEN-1:0] new_addr;       // byte address
    } redirect_t;

endpackage

//--- common/commit_settings.svh
// sizing for the commit end of the core
// ROB_DEPTH must be a power of two equal to 2**TAG_W, pointers wrap by overflow
// REG_W must cover NUM_REGS, register 0 is hard-wired to zero
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

////////////////////////////////////////
// reorder buffer
////////////////////////////////////////
`define ROB_DEPTH 32  // entries
`define TAG_W     5   // rob index width

////////////////////////////////////////
// register file
////////////////////////////////////////
`define NUM_REGS  32  // architectural regs
`define REG_W     5   // reg index width
`define XLEN      32  // data width

`endif
